// File: had_ctrl.sv
`timescale 1ns/1ps

module had_ctrl
  import had_ctrl_pkg::*;
(
  input  logic       cpuclk,
  input  logic       cpurst_b,
  input  logic       trace_req,
  input  logic       bkpt_req,
  input  logic       halt_req,
  input  logic       exit_pulse,
  output logic       dbgon,
  output had_cause_t cause
);

  had_state_e state_q;
  had_state_e state_d;
  had_cause_t cause_sel;
  logic       any_req;

  // ========================================
  // request merge and priority
  // ========================================

  assign any_req = trace_req || bkpt_req || halt_req;

  // bkpt first, then trace, halt last
  always_comb
  begin
    if (bkpt_req)
      cause_sel = CAUSE_BKPT;
    else if (trace_req)
      cause_sel = CAUSE_TRACE;
    else if (halt_req)
      cause_sel = CAUSE_HALT;
    else
      cause_sel = CAUSE_NONE;
  end

  // ========================================
  // state machine
  // ========================================

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      RUN:
      begin
        if (any_req)
          state_d = ENTER;
      end
      // one cycle for the core to drain
      ENTER:   state_d = DEBUG;
      DEBUG:
      begin
        // new requests are ignored here
        if (exit_pulse)
          state_d = RUN;
      end
      default: state_d = RUN;
    endcase
  end

  always_ff @(posedge cpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      state_q <= RUN;
    else
      state_q <= state_d;
  end

  // cause captured when leaving run
  // kept after exit until the next entry
  always_ff @(posedge cpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      cause <= CAUSE_NONE;
    else if ((state_q == RUN) && any_req)
      cause <= cause_sel;
  end

  assign dbgon = (state_q == DEBUG);

endmodule

// File: had_ctrl_pkg.sv
package had_ctrl_pkg;

  // ========================================
  // debug mode state machine
  // ========================================

  // run -> enter on any request, enter -> debug after one cycle
  typedef enum logic [1:0] {
    RUN   = 2'd0,
    ENTER = 2'd1,
    DEBUG = 2'd2
  } had_state_e;

  // ========================================
  // entry cause codes
  // ========================================

  typedef logic [1:0] had_cause_t;

  // value after reset, before any entry
  localparam had_cause_t CAUSE_NONE  = 2'd0;
  localparam had_cause_t CAUSE_TRACE = 2'd1;
  localparam had_cause_t CAUSE_BKPT  = 2'd2;
  // external halt request from the core side
  localparam had_cause_t CAUSE_HALT  = 2'd3;

endpackage

// File: had_dr_access.sv
`timescale 1ns/1ps

module had_dr_access
  import had_reg_pkg::*;
  import had_ctrl_pkg::*;
#(
  parameter int unsigned PC_WIDTH = 40
) (
  input  logic                cpuclk,
  input  logic                cpurst_b,
  input  logic                update_dr_en,
  input  had_regsel_t         reg_sel,
  input  had_data_t           wdata,
  input  had_cnt_t            trace_cnt,
  input  had_cause_t          cause,
  output had_data_t           rdata,
  output logic                otc_sel,
  output logic                trace_en,
  output logic                bkpt_en,
  output logic [PC_WIDTH-1:0] bkpt_addr,
  output logic                exit_pulse
);

  logic hcr_wr;
  logic bkpt_wr;

  // ========================================
  // register update decode
  // ========================================

  // update strobe qualified by select
  assign hcr_wr  = update_dr_en && (reg_sel == REG_HCR);
  assign bkpt_wr = update_dr_en && (reg_sel == REG_BKPT);

  // counter flops live in had_trace
  // only the select qualifier goes over
  assign otc_sel = (reg_sel == REG_OTC);

  // ========================================
  // hcr control bits
  // ========================================

  always_ff @(posedge cpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      trace_en <= 1'b0;
      bkpt_en  <= 1'b0;
    end
    else if (hcr_wr)
    begin
      trace_en <= wdata[HCR_TRACE_EN];
      bkpt_en  <= wdata[HCR_BKPT_EN];
    end
  end

  // exit command, one cycle wide with the strobe
  // state machine leaves debug at the same edge
  assign exit_pulse = hcr_wr && wdata[HCR_EXIT];

  // ========================================
  // breakpoint address
  // ========================================

  always_ff @(posedge cpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      bkpt_addr <= '0;
    else if (bkpt_wr)
      bkpt_addr <= wdata[PC_WIDTH-1:0];
  end

  // ========================================
  // read data mux
  // ========================================

  always_comb
  begin
    rdata = '0;
    case (reg_sel)
      REG_HCR:
      begin
        // exit bit always reads back zero
        rdata[HCR_TRACE_EN] = trace_en;
        rdata[HCR_BKPT_EN]  = bkpt_en;
      end
      // live counter, zero extended
      REG_OTC:   rdata[HAD_CNT_WIDTH-1:0] = trace_cnt;
      REG_BKPT:  rdata[PC_WIDTH-1:0]      = bkpt_addr;
      REG_CAUSE: rdata[1:0]               = cause;
      default:   rdata = '0;
    endcase
  end

endmodule

// File: had_inst_bkpt.sv
`timescale 1ns/1ps

module had_inst_bkpt #(
  parameter int unsigned PC_WIDTH = 40
) (
  input  logic                bkpt_en,
  input  logic [PC_WIDTH-1:0] bkpt_addr,
  input  logic [PC_WIDTH-1:0] retire_pc,
  input  logic                retire_normal,
  input  logic                split_inst,
  input  logic                dbgon,
  output logic                bkpt_req
);

  logic retire_vld;
  logic pc_hit;

  // ========================================
  // retire qualification
  // ========================================

  // same retire rules as the trace path
  // but gated by the breakpoint enable instead
  assign retire_vld = retire_normal && !split_inst && !dbgon;

  // ========================================
  // pc compare
  // ========================================

  // full width equality, no masking
  assign pc_hit = (retire_pc == bkpt_addr);

  // ========================================
  // debug request
  // ========================================

  // combinational in the retire cycle
  // trace counter uses this to hold its value
  assign bkpt_req = bkpt_en && retire_vld && pc_hit;

endmodule

// File: had_properties.sv
`timescale 1ns/1ps

module had_properties
  import had_reg_pkg::*;
  import had_ctrl_pkg::*;
(
  input logic       cpuclk,
  input logic       cpurst_b,
  input logic       trace_req,
  input logic       bkpt_req,
  input logic       halt_req,
  input logic       update_dr_en,
  input logic       otc_sel,
  input had_cnt_t   trace_cnt,
  input had_cause_t cause,
  input logic       dbgon
);

  logic any_req;
  logic otc_wr;

  assign any_req = trace_req || bkpt_req || halt_req;
  // counter load from the debug port
  assign otc_wr  = update_dr_en && otc_sel;

  // ========================================
  // debug entry timing
  // ========================================

  // run, enter, debug: request two edges back
  assert property (@(posedge cpuclk) disable iff (!cpurst_b)
    $rose(dbgon) |-> $past(any_req, 2))
    else $error("dbgon rose without a request two cycles earlier");

  // ========================================
  // counter and cause
  // ========================================

  // zero only leaves zero by a load, no wrap
  assert property (@(posedge cpuclk) disable iff (!cpurst_b)
    (!$past(otc_wr) && ($past(trace_cnt) == '0)) |-> (trace_cnt == '0))
    else $error("trace counter decremented below zero");

  // cause held for the whole debug stay
  assert property (@(posedge cpuclk) disable iff (!cpurst_b)
    (dbgon && $past(dbgon)) |-> $stable(cause))
    else $error("cause changed while dbgon was high");

endmodule

bind had_top had_properties u_props (
  .cpuclk       (cpuclk),
  .cpurst_b     (cpurst_b),
  .trace_req    (trace_req),
  .bkpt_req     (bkpt_req),
  .halt_req     (halt_req),
  .update_dr_en (update_dr_en),
  .otc_sel      (otc_sel),
  .trace_cnt    (trace_cnt),
  .cause        (cause),
  .dbgon        (dbgon)
);

// File: had_reg_pkg.sv
package had_reg_pkg;

  // ========================================
  // debug port word and field widths
  // ========================================

  localparam int unsigned HAD_DATA_WIDTH = 64;
  localparam int unsigned HAD_CNT_WIDTH  = 8;

  // full data word on the debug port
  typedef logic [HAD_DATA_WIDTH-1:0] had_data_t;
  // register select from the update stage
  typedef logic [2:0] had_regsel_t;
  // one-shot trace counter value
  typedef logic [HAD_CNT_WIDTH-1:0] had_cnt_t;

  // ========================================
  // register select codes
  // ========================================

  localparam had_regsel_t REG_HCR   = 3'd0;
  localparam had_regsel_t REG_OTC   = 3'd1;
  localparam had_regsel_t REG_BKPT  = 3'd2;
  // cause is read-only, writes are dropped
  localparam had_regsel_t REG_CAUSE = 3'd3;

  // hcr bit positions
  localparam int unsigned HCR_TRACE_EN = 0;
  localparam int unsigned HCR_BKPT_EN  = 1;
  // exit command, never stored, reads as zero
  localparam int unsigned HCR_EXIT     = 2;

endpackage

// File: had_tb.sv
`timescale 1ns/1ps

module had_tb
  import had_reg_pkg::*;
  import had_ctrl_pkg::*;
();

  localparam int unsigned PC_WIDTH     = 40;
  localparam int unsigned RESET_CYCLES = 8;
  localparam logic [PC_WIDTH-1:0] BKPT_PC = 40'h80_0000_1000;

  // row operations
  // rret takes a random pc
  // split is a retire with split_inst set
  typedef enum logic [2:0] {
    OP_IDLE, OP_WR, OP_RD, OP_RET, OP_RRET, OP_SPLIT, OP_HALT
  } op_e;

  typedef struct packed {
    op_e                 op;
    had_regsel_t         sel;
    had_data_t           data;
    logic [PC_WIDTH-1:0] pc;
    had_data_t           exp;
  } row_t;

  logic                cpuclk;
  logic                cpurst_b;
  logic                update_dr_en;
  had_regsel_t         reg_sel;
  had_data_t           wdata;
  had_data_t           rdata;
  logic                retire_normal;
  logic                split_inst;
  logic [PC_WIDTH-1:0] retire_pc;
  logic                halt_req;
  logic                dbgon;

  row_t        rows[$];
  string       names[$];
  logic [31:0] lcg_state;
  int          cycles;
  int          timeout_limit;

  // reference model copies
  had_state_e          m_state;
  had_cnt_t            m_cnt;
  logic                m_trace_en;
  logic                m_bkpt_en;
  logic [PC_WIDTH-1:0] m_bkpt;

  had_top #(
    .PC_WIDTH (PC_WIDTH)
  ) uut (
    .cpuclk        (cpuclk),
    .cpurst_b      (cpurst_b),
    .update_dr_en  (update_dr_en),
    .reg_sel       (reg_sel),
    .wdata         (wdata),
    .rdata         (rdata),
    .retire_normal (retire_normal),
    .split_inst    (split_inst),
    .retire_pc     (retire_pc),
    .halt_req      (halt_req),
    .dbgon         (dbgon)
  );

  // ========================================
  // clock and timeout
  // ========================================

  initial cpuclk = 1'b0;
  always #20 cpuclk = ~cpuclk;

  always @(posedge cpuclk)
  begin
    cycles = cycles + 1;
    if ((timeout_limit > 0) && (cycles >= timeout_limit))
      stop_on_failure($sformatf("timeout, table not finished after %0d cycles", cycles));
  end

  // ========================================
  // helpers
  // ========================================

  task automatic stop_on_failure(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic check_value(input string name, input had_data_t expected,
                             input had_data_t actual);
    if (actual !== expected)
      stop_on_failure($sformatf("[FAIL] %s expected %h actual %h", name, expected, actual));
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic add_row(input string name, input op_e op, input had_regsel_t sel,
                         input had_data_t data, input logic [PC_WIDTH-1:0] pc,
                         input had_data_t exp);
    row_t r;
    r.op   = op;
    r.sel  = sel;
    r.data = data;
    r.pc   = pc;
    r.exp  = exp;
    rows.push_back(r);
    names.push_back(name);
  endtask

  // one cycle of the reference model from the debug rules
  task automatic model_step(input row_t r, input logic [PC_WIDTH-1:0] pc);
    logic vld;
    logic tvld;
    logic breq;
    logic treq;
    logic hcr_wr;
    vld    = ((r.op == OP_RET) || (r.op == OP_RRET)) && (m_state != DEBUG);
    tvld   = vld && m_trace_en;
    breq   = vld && m_bkpt_en && (pc == m_bkpt);
    treq   = tvld && (m_cnt == '0);
    hcr_wr = (r.op == OP_WR) && (r.sel == REG_HCR);
    if ((r.op == OP_WR) && (r.sel == REG_OTC))
      m_cnt = r.data[HAD_CNT_WIDTH-1:0];
    else if (tvld && (m_cnt != '0) && !breq)
      m_cnt = m_cnt - 8'd1;
    if (hcr_wr)
    begin
      m_trace_en = r.data[HCR_TRACE_EN];
      m_bkpt_en  = r.data[HCR_BKPT_EN];
    end
    if ((r.op == OP_WR) && (r.sel == REG_BKPT))
      m_bkpt = r.data[PC_WIDTH-1:0];
    case (m_state)
      RUN:
      begin
        if (breq || treq || (r.op == OP_HALT))
          m_state = ENTER;
      end
      ENTER:   m_state = DEBUG;
      default:
      begin
        if (hcr_wr && r.data[HCR_EXIT])
          m_state = RUN;
      end
    endcase
  endtask

  // ========================================
  // stimulus table
  // ========================================

  task automatic build_table();
    add_row("reg_access", OP_RD, REG_CAUSE, 64'd0, '0, 64'd0);
    add_row("reg_access", OP_WR, REG_HCR, 64'd3, '0, 64'd0);
    add_row("reg_access", OP_RD, REG_HCR, 64'd0, '0, 64'd3);
    add_row("reg_access", OP_WR, REG_BKPT, 64'hffff_ff80_0000_1000, '0, 64'd0);
    add_row("reg_access", OP_RD, REG_BKPT, 64'd0, '0, 64'h0000_0080_0000_1000);
    add_row("reg_access", OP_WR, REG_OTC, 64'd3, '0, 64'd0);
    add_row("reg_access", OP_RD, REG_OTC, 64'd0, '0, 64'd3);
    // counting with split and trace-off retires skipped
    add_row("trace_count", OP_RRET, REG_OTC, 64'd0, '0, 64'd0);
    add_row("trace_count", OP_RD, REG_OTC, 64'd0, '0, 64'd2);
    add_row("trace_count", OP_SPLIT, REG_OTC, 64'd0, BKPT_PC, 64'd0);
    add_row("trace_count", OP_RD, REG_OTC, 64'd0, '0, 64'd2);
    add_row("trace_count", OP_WR, REG_HCR, 64'd2, '0, 64'd0);
    add_row("trace_count", OP_RRET, REG_OTC, 64'd0, '0, 64'd0);
    add_row("trace_count", OP_RD, REG_OTC, 64'd0, '0, 64'd2);
    add_row("trace_count", OP_WR, REG_HCR, 64'd3, '0, 64'd0);
    add_row("trace_count", OP_RRET, REG_OTC, 64'd0, '0, 64'd0);
    add_row("trace_count", OP_RRET, REG_OTC, 64'd0, '0, 64'd0);
    add_row("trace_count", OP_RD, REG_OTC, 64'd0, '0, 64'd0);
    // retire at zero count
    add_row("trace_entry", OP_RRET, REG_OTC, 64'd0, '0, 64'd0);
    add_row("trace_entry", OP_IDLE, REG_OTC, 64'd0, '0, 64'd0);
    add_row("trace_entry", OP_IDLE, REG_OTC, 64'd0, '0, 64'd0);
    add_row("trace_entry", OP_RD, REG_CAUSE, 64'd0, '0, 64'd1);
    add_row("trace_entry", OP_WR, REG_HCR, 64'd7, '0, 64'd0);
    add_row("trace_entry", OP_IDLE, REG_HCR, 64'd0, '0, 64'd0);
    add_row("trace_entry", OP_RD, REG_HCR, 64'd0, '0, 64'd3);
    // breakpoint hit holds the count
    add_row("breakpoint", OP_WR, REG_OTC, 64'd5, '0, 64'd0);
    add_row("breakpoint", OP_RET, REG_OTC, 64'd0, BKPT_PC, 64'd0);
    add_row("breakpoint", OP_IDLE, REG_OTC, 64'd0, '0, 64'd0);
    add_row("breakpoint", OP_IDLE, REG_OTC, 64'd0, '0, 64'd0);
    add_row("breakpoint", OP_RD, REG_OTC, 64'd0, '0, 64'd5);
    add_row("breakpoint", OP_RD, REG_CAUSE, 64'd0, '0, 64'd2);
    add_row("breakpoint", OP_RET, REG_OTC, 64'd0, BKPT_PC, 64'd0);
    add_row("breakpoint", OP_RRET, REG_OTC, 64'd0, '0, 64'd0);
    add_row("breakpoint", OP_RD, REG_OTC, 64'd0, '0, 64'd5);
    add_row("breakpoint", OP_WR, REG_HCR, 64'd7, '0, 64'd0);
    add_row("breakpoint", OP_IDLE, REG_OTC, 64'd0, '0, 64'd0);
    // halt then retires in debug then exit
    add_row("halt_exit", OP_HALT, REG_OTC, 64'd0, '0, 64'd0);
    add_row("halt_exit", OP_IDLE, REG_OTC, 64'd0, '0, 64'd0);
    add_row("halt_exit", OP_IDLE, REG_OTC, 64'd0, '0, 64'd0);
    add_row("halt_exit", OP_RD, REG_CAUSE, 64'd0, '0, 64'd3);
    add_row("halt_exit", OP_RRET, REG_OTC, 64'd0, '0, 64'd0);
    add_row("halt_exit", OP_RD, REG_OTC, 64'd0, '0, 64'd5);
    add_row("halt_exit", OP_WR, REG_HCR, 64'd4, '0, 64'd0);
    add_row("halt_exit", OP_IDLE, REG_HCR, 64'd0, '0, 64'd0);
    add_row("halt_exit", OP_RD, REG_HCR, 64'd0, '0, 64'd0);
    // bkpt and trace in one retire with bkpt winning
    add_row("priority", OP_WR, REG_HCR, 64'd3, '0, 64'd0);
    add_row("priority", OP_WR, REG_OTC, 64'd0, '0, 64'd0);
    add_row("priority", OP_RET, REG_OTC, 64'd0, BKPT_PC, 64'd0);
    add_row("priority", OP_IDLE, REG_OTC, 64'd0, '0, 64'd0);
    add_row("priority", OP_IDLE, REG_OTC, 64'd0, '0, 64'd0);
    add_row("priority", OP_RD, REG_CAUSE, 64'd0, '0, 64'd2);
    add_row("priority", OP_WR, REG_HCR, 64'd7, '0, 64'd0);
    add_row("priority", OP_IDLE, REG_OTC, 64'd0, '0, 64'd0);
    add_row("priority", OP_RD, REG_CAUSE, 64'd0, '0, 64'd2);
  endtask

  // ========================================
  // main sequence
  // ========================================

  initial
  begin
    logic [PC_WIDTH-1:0] pc;
    op_e                 op;
    cpurst_b      <= 1'b0;
    update_dr_en  <= 1'b0;
    reg_sel       <= REG_HCR;
    wdata         <= '0;
    retire_normal <= 1'b0;
    split_inst    <= 1'b0;
    retire_pc     <= '0;
    halt_req      <= 1'b0;
    cycles        = 0;
    lcg_state     = 32'he97098ad;
    m_state       = RUN;
    m_cnt         = '0;
    m_trace_en    = 1'b0;
    m_bkpt_en     = 1'b0;
    m_bkpt        = '0;
    build_table();
    timeout_limit = rows.size() * 4 + 50;
    repeat (RESET_CYCLES) @(posedge cpuclk);
    cpurst_b <= 1'b1;
    for (int i = 0; i < rows.size(); i++)
    begin
      @(posedge cpuclk);
      op = rows[i].op;
      pc = rows[i].pc;
      // upper byte zero so never the breakpoint
      if (op == OP_RRET)
      begin
        lcg_state = lcg_next(lcg_state);
        pc = {8'h00, lcg_state};
      end
      update_dr_en  <= (op == OP_WR);
      reg_sel       <= rows[i].sel;
      wdata         <= rows[i].data;
      retire_normal <= (op == OP_RET) || (op == OP_RRET) || (op == OP_SPLIT);
      split_inst    <= (op == OP_SPLIT);
      retire_pc     <= pc;
      halt_req      <= (op == OP_HALT);
      // outputs settled half a cycle later
      @(negedge cpuclk);
      check_value($sformatf("%s row %0d dbgon", names[i], i),
                  {63'd0, m_state == DEBUG}, {63'd0, dbgon});
      if (op == OP_RD)
        check_value($sformatf("%s row %0d rdata", names[i], i), rows[i].exp, rdata);
      model_step(rows[i], pc);
    end
    @(posedge cpuclk);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// File: had_top.sv
`timescale 1ns/1ps

module had_top
  import had_reg_pkg::*;
  import had_ctrl_pkg::*;
#(
  parameter int unsigned PC_WIDTH = 40
) (
  input  logic                cpuclk,
  input  logic                cpurst_b,
  // debug port
  input  logic                update_dr_en,
  input  had_regsel_t         reg_sel,
  input  had_data_t           wdata,
  output had_data_t           rdata,
  // core side
  input  logic                retire_normal,
  input  logic                split_inst,
  input  logic [PC_WIDTH-1:0] retire_pc,
  input  logic                halt_req,
  output logic                dbgon
);

  // ========================================
  // internal wires
  // ========================================

  // register block to datapath
  logic                trace_en;
  logic                bkpt_en;
  logic [PC_WIDTH-1:0] bkpt_addr;
  logic                otc_sel;
  logic                exit_pulse;

  // requests into the state machine
  logic                trace_req;
  logic                bkpt_req;

  // status back to the read mux
  had_cnt_t            trace_cnt;
  had_cause_t          cause;

  // ========================================
  // register access
  // ========================================

  had_dr_access #(
    .PC_WIDTH (PC_WIDTH)
  ) u_dr_access (
    .cpuclk       (cpuclk),
    .cpurst_b     (cpurst_b),
    .update_dr_en (update_dr_en),
    .reg_sel      (reg_sel),
    .wdata        (wdata),
    .trace_cnt    (trace_cnt),
    .cause        (cause),
    .rdata        (rdata),
    .otc_sel      (otc_sel),
    .trace_en     (trace_en),
    .bkpt_en      (bkpt_en),
    .bkpt_addr    (bkpt_addr),
    .exit_pulse   (exit_pulse)
  );

  // ========================================
  // trace counter and breakpoint
  // ========================================

  // counter load takes the low byte only
  had_trace u_trace (
    .cpuclk        (cpuclk),
    .cpurst_b      (cpurst_b),
    .trace_en      (trace_en),
    .bkpt_req      (bkpt_req),
    .otc_sel       (otc_sel),
    .update_dr_en  (update_dr_en),
    .wdata         (wdata[HAD_CNT_WIDTH-1:0]),
    .retire_normal (retire_normal),
    .split_inst    (split_inst),
    .dbgon         (dbgon),
    .trace_req     (trace_req),
    .trace_cnt     (trace_cnt)
  );

  had_inst_bkpt #(
    .PC_WIDTH (PC_WIDTH)
  ) u_inst_bkpt (
    .bkpt_en       (bkpt_en),
    .bkpt_addr     (bkpt_addr),
    .retire_pc     (retire_pc),
    .retire_normal (retire_normal),
    .split_inst    (split_inst),
    .dbgon         (dbgon),
    .bkpt_req      (bkpt_req)
  );

  // ========================================
  // debug mode control
  // ========================================

  had_ctrl u_ctrl (
    .cpuclk     (cpuclk),
    .cpurst_b   (cpurst_b),
    .trace_req  (trace_req),
    .bkpt_req   (bkpt_req),
    .halt_req   (halt_req),
    .exit_pulse (exit_pulse),
    .dbgon      (dbgon),
    .cause      (cause)
  );

endmodule

// File: had_trace.sv
`timescale 1ns/1ps

module had_trace
  import had_reg_pkg::*;
(
  input  logic     cpuclk,
  input  logic     cpurst_b,
  input  logic     trace_en,
  input  logic     bkpt_req,
  input  logic     otc_sel,
  input  logic     update_dr_en,
  input  had_cnt_t wdata,
  input  logic     retire_normal,
  input  logic     split_inst,
  input  logic     dbgon,
  output logic     trace_req,
  output had_cnt_t trace_cnt
);

  had_cnt_t cnt_q;
  logic     trace_vld;
  logic     cnt_zero;
  logic     cnt_dec;

  // ========================================
  // retire qualification
  // ========================================

  // normal retire, last part of any split
  // outside debug and with tracing switched on
  assign trace_vld = retire_normal && !split_inst && !dbgon && trace_en;

  assign cnt_zero = (cnt_q == '0);

  // breakpoint in the same retire wins, count held
  assign cnt_dec = trace_vld && !cnt_zero && !bkpt_req;

  // ========================================
  // counter
  // ========================================

  always_ff @(posedge cpuclk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      cnt_q <= '0;
    else if (update_dr_en && otc_sel)
      cnt_q <= wdata;
    else if (cnt_dec)
      cnt_q <= cnt_q - 1'b1;
  end

  // back to the register read mux
  assign trace_cnt = cnt_q;

  // ========================================
  // debug request
  // ========================================

  // qualified retire finds the count already spent
  assign trace_req = trace_vld && cnt_zero;

endmodule

// File: run.sh
#!/bin/sh
# build and run the debug unit testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f src.f --top-module had_tb -o had_sim
./obj_dir/had_sim 2>&1 | tee sim.log
if grep -qx "STATUS: PASS" sim.log
then
  echo "had_tb run ok"
else
  echo "had_tb run failed"
  exit 1
fi

// File: src.f
had_reg_pkg.sv
had_ctrl_pkg.sv
had_dr_access.sv
had_trace.sv
had_inst_bkpt.sv
had_ctrl.sv
had_top.sv
had_properties.sv
had_tb.sv
